// File: filelist.f
logic/rv_core_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/hazard_unit.sv
logic/mem_wb_stage.sv
logic/rv_core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f filelist.f -o tb_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// File: testbench/tb_top.sv
`timescale 1ns/10ps

module tb_top
  import rv_core_pkg::*;
();

  localparam int          N_INSTR        = 200;
  localparam int          PROG_LEN       = N_INSTR + 1;
  localparam int          MEM_WORDS      = 64;
  localparam int          TIMEOUT_CYCLES = N_INSTR * 8 + 100;
  localparam int unsigned SEED           = 42048;

  logic      clk;
  logic      rst_i;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  logic      dmem_ack;
  retire_t   retire;
  word_t     rom [PROG_LEN];
  word_t     mem_init [MEM_WORDS];
  word_t     dmem [MEM_WORDS];
  logic      done;
  int        mismatch_cnt;
  int        fail_cnt;
  int        retired_cnt;

  // ========================================
  // instruction encoders
  // ========================================
  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // sw with x0 as base
  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                   logic is_ne);
    return {imm[12], imm[10:5], rs2, rs1, 2'b00, is_ne, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic word_t random_instr(int idx);
    int unsigned kind;
    logic [2:0]  f3;
    logic        alt;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    logic [5:0]  woff;
    logic [12:0] off;
    kind = $urandom_range(0, 9);
    f3   = 3'($urandom_range(0, 7));
    alt  = 1'($urandom_range(0, 1));
    rd   = reg_idx_t'($urandom_range(0, 7));
    rs1  = reg_idx_t'($urandom_range(0, 7));
    rs2  = reg_idx_t'($urandom_range(0, 7));
    imm  = 12'($urandom);
    woff = 6'($urandom_range(0, MEM_WORDS - 1));
    off  = 13'($urandom_range(2, 4) * 4);
    // a forward jump needs room before the end loop
    if (kind >= 8 && idx + 4 > N_INSTR) begin
      kind = 0;
    end
    case (kind)
      0, 1, 2: begin
        return r_type(((f3 == 3'b000 || f3 == 3'b101) && alt) ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd);
      end
      3, 4: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {(f3 == 3'b101 && alt) ? 7'h20 : 7'h00, imm[4:0]};
        end
        return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
      end
      5:       return {20'($urandom), rd, OPC_LUI};
      6:       return i_type({4'b0000, woff, 2'b00}, 5'd0, 3'b010, rd, OPC_LOAD);
      7:       return s_type({4'b0000, woff, 2'b00}, rs2);
      8:       return b_type(off, rs2, rs1, alt);
      default: return j_type(21'(off), rd);
    endcase
  endfunction

  function automatic word_t fill_word(int idx);
    return 32'h5a3c_0000 ^ (word_t'(idx) * 32'h0001_0203) ^ (word_t'(idx) << 26);
  endfunction

  // ========================================
  // DUT and checker
  // ========================================
  assign imem_data = (imem_addr < word_t'(PROG_LEN * 4)) ? rom[imem_addr[9:2]] : NOP_INST;

  rv_core_top #(
    .RESET_PC(32'h0000_0000)
  ) dut0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .dmem_req_o  (dmem_req),
    .dmem_rdata_i(dmem_rdata),
    .dmem_ack_i  (dmem_ack),
    .retire_o    (retire)
  );

  tb_checker #(
    .PROG_LEN (PROG_LEN),
    .MEM_WORDS(MEM_WORDS)
  ) chk0 (
    .clk           (clk),
    .rst_i         (rst_i),
    .prog_i        (rom),
    .mem_init_i    (mem_init),
    .retire_i      (retire),
    .dmem_req_i    (dmem_req),
    .dmem_rdata_i  (dmem_rdata),
    .dmem_ack_i    (dmem_ack),
    .done_o        (done),
    .mismatch_cnt_o(mismatch_cnt),
    .fail_cnt_o    (fail_cnt),
    .retired_o     (retired_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // data memory, ack 1 to 4 cycles after the request is seen
  initial begin
    int unsigned wait_left;
    logic        pending;
    dmem_ack   = 1'b0;
    dmem_rdata = '0;
    pending    = 1'b0;
    wait_left  = 0;
    forever begin
      @(posedge clk);
      #1;
      dmem_ack = 1'b0;
      if (rst_i) begin
        pending = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
          dmem[i] = mem_init[i];
        end
      end else if (pending) begin
        if (wait_left <= 1) begin
          pending  = 1'b0;
          dmem_ack = 1'b1;
          if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
          end else begin
            dmem_rdata = dmem[dmem_req.addr[7:2]];
          end
        end else begin
          wait_left--;
        end
      end else if (dmem_req.req) begin
        pending   = 1'b1;
        wait_left = $urandom_range(1, 4);
      end
    end
  end

  initial begin
    int   cycles;
    logic timed_out;
    rst_i = 1'b1;
    void'($urandom(SEED));
    for (int i = 0; i < N_INSTR; i++) begin
      do begin
        rom[i] = random_instr(i);
      end while (rom[i] == NOP_INST);
    end
    // program ends in a jump to itself
    rom[N_INSTR] = j_type(21'd0, 5'd0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_init[i] = fill_word(i);
    end
    repeat (4) @(posedge clk);
    #1;
    rst_i  = 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    timed_out = !done;
    if (timed_out) begin
      $display("timeout: the end loop was not reached within %0d cycles", TIMEOUT_CYCLES);
    end
    $display("totals: %0d mismatches, %0d other errors, %0d timeouts, %0d retired",
             mismatch_cnt, fail_cnt, timed_out ? 1 : 0, retired_cnt);
    if (timed_out || mismatch_cnt != 0 || fail_cnt != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

// File: testbench/tb_checker.sv
`timescale 1ns/10ps

module tb_checker
  import rv_core_pkg::*;
#(
  parameter int PROG_LEN  = 201,
  parameter int MEM_WORDS = 64
) (
  input  logic      clk,
  input  logic      rst_i,
  input  word_t     prog_i [PROG_LEN],
  input  word_t     mem_init_i [MEM_WORDS],
  input  retire_t   retire_i,
  input  dmem_req_t dmem_req_i,
  input  word_t     dmem_rdata_i,
  input  logic      dmem_ack_i,
  output logic      done_o,
  output int        mismatch_cnt_o,
  output int        fail_cnt_o,
  output int        retired_o
);

  typedef struct packed {
    logic  we;
    word_t addr;
    word_t data;
  } bus_rec_t;

  localparam int MAX_STEPS = 4 * PROG_LEN;

  retire_t  exp_retire [$];
  bus_rec_t exp_bus [$];
  logic     model_built;

  task automatic compare_field(string name, word_t got, word_t exp);
    if (got !== exp) begin
      mismatch_cnt_o++;
      $display("MISMATCH %s: got %08h expected %08h", name, got, exp);
    end
  endtask

  task automatic report_fail(string what);
    fail_cnt_o++;
    $display("error: %s", what);
  endtask

  // ========================================
  // instruction-set model
  // ========================================
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs the program to its end loop and queues every event
  task automatic build_model();
    word_t    x [32];
    word_t    mem [MEM_WORDS];
    word_t    pc;
    word_t    next_pc;
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    i_imm;
    retire_t  rec;
    bus_rec_t acc;
    int       steps;
    logic     at_end;
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = mem_init_i[i];
    end
    exp_retire.delete();
    exp_bus.delete();
    pc     = '0;
    steps  = 0;
    at_end = 1'b0;
    while (!at_end && steps < MAX_STEPS) begin
      if (pc >= word_t'(PROG_LEN * 4)) begin
        report_fail("model pc left the program");
        return;
      end
      ins     = prog_i[pc[9:2]];
      a       = x[ins[19:15]];
      b       = x[ins[24:20]];
      i_imm   = {{20{ins[31]}}, ins[31:20]};
      next_pc = pc + 32'd4;
      rec     = '{valid: 1'b1, pc: pc, rd: ins[11:7], reg_write: 1'b0, wdata: '0};
      case (ins[6:0])
        OPC_OP: begin
          rec.reg_write = 1'b1;
          rec.wdata     = alu_ref(ins[14:12], ins[30], a, b);
        end
        OPC_OP_IMM: begin
          rec.reg_write = 1'b1;
          rec.wdata     = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, i_imm);
        end
        OPC_LUI: begin
          rec.reg_write = 1'b1;
          rec.wdata     = {ins[31:12], 12'h000};
        end
        OPC_LOAD: begin
          acc           = '{we: 1'b0, addr: a + i_imm, data: '0};
          acc.data      = mem[acc.addr[7:2]];
          rec.reg_write = 1'b1;
          rec.wdata     = acc.data;
          exp_bus.push_back(acc);
        end
        OPC_STORE: begin
          acc = '{we: 1'b1, addr: a + {{20{ins[31]}}, ins[31:25], ins[11:7]}, data: b};
          mem[acc.addr[7:2]] = b;
          exp_bus.push_back(acc);
        end
        OPC_BRANCH: begin
          if ((a == b) != ins[12]) begin
            next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        OPC_JAL: begin
          rec.reg_write = 1'b1;
          rec.wdata     = pc + 32'd4;
          next_pc       = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: report_fail($sformatf("program holds an unknown instruction %08h", ins));
      endcase
      if (rec.reg_write && rec.rd != '0) begin
        x[rec.rd] = rec.wdata;
      end
      exp_retire.push_back(rec);
      at_end  = (next_pc == pc);
      pc      = next_pc;
      steps++;
    end
    if (!at_end) begin
      report_fail("model never reached the end loop");
    end
  endtask

  // ========================================
  // event checks
  // ========================================
  task automatic check_bus();
    bus_rec_t exp;
    if (!dmem_req_i.req) begin
      report_fail("data ack arrived with no request pending");
      return;
    end
    if (exp_bus.size() == 0) begin
      report_fail("data access that the program never makes");
      return;
    end
    exp = exp_bus.pop_front();
    compare_field("dmem_req.we", 32'(dmem_req_i.we), 32'(exp.we));
    compare_field("dmem_req.addr", dmem_req_i.addr, exp.addr);
    if (exp.we) begin
      compare_field("dmem_req.wdata", dmem_req_i.wdata, exp.data);
    end else begin
      compare_field("dmem_rdata", dmem_rdata_i, exp.data);
    end
  endtask

  task automatic check_retire();
    retire_t exp;
    if (exp_retire.size() == 0) begin
      report_fail("instruction retired beyond the end of the program");
      return;
    end
    exp = exp_retire.pop_front();
    retired_o++;
    compare_field("retire.pc", retire_i.pc, exp.pc);
    compare_field("retire.reg_write", 32'(retire_i.reg_write), 32'(exp.reg_write));
    if (exp.reg_write) begin
      compare_field("retire.rd", 32'(retire_i.rd), 32'(exp.rd));
      // x0 keeps no value
      if (exp.rd != '0) begin
        compare_field("retire.wdata", retire_i.wdata, exp.wdata);
      end
    end
    // the end loop was the last queued record
    if (exp_retire.size() == 0) begin
      if (exp_bus.size() != 0) begin
        report_fail($sformatf("%0d data accesses never reached the bus", exp_bus.size()));
      end
      done_o = 1'b1;
    end
  endtask

  // sampled at the falling edge, away from input changes
  always @(negedge clk) begin
    if (rst_i) begin
      model_built    = 1'b0;
      done_o         = 1'b0;
      mismatch_cnt_o = 0;
      fail_cnt_o     = 0;
      retired_o      = 0;
    end else begin
      if (!model_built) begin
        build_model();
        model_built = 1'b1;
      end
      if (dmem_ack_i && !done_o) begin
        check_bus();
      end
      if (retire_i.valid && !done_o) begin
        check_retire();
      end
    end
  end

endmodule

// File: logic/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clk,
  input  logic      rst_i,
  output word_t     imem_addr_o,
  input  word_t     imem_data_i,
  output dmem_req_t dmem_req_o,
  input  word_t     dmem_rdata_i,
  input  logic      dmem_ack_i,
  output retire_t   retire_o
);

  if_id_t   if_id_q;
  id_ex_t   id_ex_q;
  ex_mem_t  ex_mem_q;
  mem_wb_t  mem_wb_q;
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  word_t    rf_rdata1;
  word_t    rf_rdata2;
  word_t    branch_target;
  word_t    mem_fwd;
  logic     redirect;
  logic     mem_busy;
  logic     fetch_en;
  logic     decode_en;
  logic     exec_en;
  logic     mem_en;
  logic     flush_if_id;
  logic     flush_id_ex;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  fetch_stage #(
    .RESET_PC(RESET_PC)
  ) fetch0 (
    .clk        (clk),
    .rst_i      (rst_i),
    .en_i       (fetch_en),
    .flush_i    (flush_if_id),
    .redirect_i (redirect),
    .target_i   (branch_target),
    .imem_addr_o(imem_addr_o),
    .imem_data_i(imem_data_i),
    .if_id_o    (if_id_q)
  );

  decode_stage decode0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .en_i    (decode_en),
    .flush_i (flush_id_ex),
    .if_id_i (if_id_q),
    .rs1_o   (id_rs1),
    .rs2_o   (id_rs2),
    .rdata1_i(rf_rdata1),
    .rdata2_i(rf_rdata2),
    .id_ex_o (id_ex_q)
  );

  // written from the writeback record
  reg_file regs0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .raddr1_i(id_rs1),
    .raddr2_i(id_rs2),
    .waddr_i (mem_wb_q.rd),
    .we_i    (mem_wb_q.reg_write),
    .wdata_i (mem_wb_q.wdata),
    .rdata1_o(rf_rdata1),
    .rdata2_o(rf_rdata2)
  );

  execute_stage exec0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .en_i      (exec_en),
    .id_ex_i   (id_ex_q),
    .fwd_a_i   (fwd_a),
    .fwd_b_i   (fwd_b),
    .mem_fwd_i (mem_fwd),
    .wb_fwd_i  (mem_wb_q.wdata),
    .redirect_o(redirect),
    .target_o  (branch_target),
    .ex_mem_o  (ex_mem_q)
  );

  mem_wb_stage mem0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .en_i        (mem_en),
    .ex_mem_i    (ex_mem_q),
    .dmem_req_o  (dmem_req_o),
    .dmem_rdata_i(dmem_rdata_i),
    .dmem_ack_i  (dmem_ack_i),
    .mem_busy_o  (mem_busy),
    .mem_fwd_o   (mem_fwd),
    .mem_wb_o    (mem_wb_q),
    .retire_o    (retire_o)
  );

  hazard_unit hazard0 (
    .id_rs1_i     (id_rs1),
    .id_rs2_i     (id_rs2),
    .id_ex_i      (id_ex_q),
    .ex_mem_i     (ex_mem_q),
    .mem_wb_i     (mem_wb_q),
    .redirect_i   (redirect),
    .mem_busy_i   (mem_busy),
    .fetch_en_o   (fetch_en),
    .decode_en_o  (decode_en),
    .exec_en_o    (exec_en),
    .mem_en_o     (mem_en),
    .flush_if_id_o(flush_if_id),
    .flush_id_ex_o(flush_id_ex),
    .fwd_a_o      (fwd_a),
    .fwd_b_o      (fwd_b)
  );

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  logic      en_i,
  input  ex_mem_t   ex_mem_i,
  output dmem_req_t dmem_req_o,
  input  word_t     dmem_rdata_i,
  input  logic      dmem_ack_i,
  output logic      mem_busy_o,
  output word_t     mem_fwd_o,
  output mem_wb_t   mem_wb_o,
  output retire_t   retire_o
);

  logic  mem_access;
  logic  advance;
  logic  wb_fresh_q;
  word_t wb_value;

  // ========================================
  // data bus
  // ========================================
  assign mem_access = ex_mem_i.valid & (ex_mem_i.ctrl.mem_read | ex_mem_i.ctrl.mem_write);
  assign mem_busy_o = mem_access & ~dmem_ack_i;
  assign dmem_req_o = '{req:   mem_access,
                        we:    ex_mem_i.ctrl.mem_write,
                        addr:  ex_mem_i.result,
                        wdata: ex_mem_i.store_data};

  assign mem_fwd_o = ex_mem_i.result;
  assign wb_value  = ex_mem_i.ctrl.mem_read ? dmem_rdata_i : ex_mem_i.result;
  assign advance   = en_i & ~mem_busy_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_wb_o <= '0;
    end else if (advance) begin
      mem_wb_o.pc        <= ex_mem_i.pc;
      mem_wb_o.rd        <= ex_mem_i.rd;
      mem_wb_o.wdata     <= wb_value;
      mem_wb_o.reg_write <= ex_mem_i.ctrl.reg_write & ex_mem_i.valid;
      mem_wb_o.valid     <= ex_mem_i.valid;
    end
  end

  // mem_wb stays put during a stall, report it only once
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_fresh_q <= 1'b0;
    end else begin
      wb_fresh_q <= advance;
    end
  end

  assign retire_o = '{valid:     mem_wb_o.valid & wb_fresh_q,
                      pc:        mem_wb_o.pc,
                      rd:        mem_wb_o.rd,
                      reg_write: mem_wb_o.reg_write,
                      wdata:     mem_wb_o.wdata};

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
  import rv_core_pkg::*;
(
  input  reg_idx_t id_rs1_i,
  input  reg_idx_t id_rs2_i,
  input  id_ex_t   id_ex_i,
  input  ex_mem_t  ex_mem_i,
  input  mem_wb_t  mem_wb_i,
  input  logic     redirect_i,
  input  logic     mem_busy_i,
  output logic     fetch_en_o,
  output logic     decode_en_o,
  output logic     exec_en_o,
  output logic     mem_en_o,
  output logic     flush_if_id_o,
  output logic     flush_id_ex_o,
  output fwd_sel_e fwd_a_o,
  output fwd_sel_e fwd_b_o
);

  logic mem_writes;
  logic wb_writes;
  logic load_use;

  // memory stage has the newer value, so it is checked first
  function automatic fwd_sel_e fwd_pick(reg_idx_t rs, logic mem_wr, reg_idx_t mem_rd,
                                        logic wb_wr, reg_idx_t wb_rd);
    if (rs == '0) begin
      return FWD_REG;
    end
    if (mem_wr && (mem_rd == rs)) begin
      return FWD_MEM;
    end
    if (wb_wr && (wb_rd == rs)) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  assign mem_writes = ex_mem_i.valid & ex_mem_i.ctrl.reg_write;
  assign wb_writes  = mem_wb_i.valid & mem_wb_i.reg_write;

  assign fwd_a_o = fwd_pick(id_ex_i.rs1, mem_writes, ex_mem_i.rd, wb_writes, mem_wb_i.rd);
  assign fwd_b_o = fwd_pick(id_ex_i.rs2, mem_writes, ex_mem_i.rd, wb_writes, mem_wb_i.rd);

  // load in execute feeding the instruction in decode
  assign load_use = id_ex_i.valid & id_ex_i.ctrl.mem_read & (id_ex_i.rd != '0) &
                    ((id_ex_i.rd == id_rs1_i) | (id_ex_i.rd == id_rs2_i));

  // ========================================
  // enables and flushes
  // ========================================
  // a waiting bus access freezes every stage
  assign fetch_en_o    = ~mem_busy_i & ~load_use;
  assign decode_en_o   = ~mem_busy_i;
  assign exec_en_o     = ~mem_busy_i;
  assign mem_en_o      = ~mem_busy_i;
  assign flush_if_id_o = redirect_i;
  assign flush_id_ex_o = redirect_i | load_use;

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  id_ex_t   id_ex_i,
  input  fwd_sel_e fwd_a_i,
  input  fwd_sel_e fwd_b_i,
  input  word_t    mem_fwd_i,
  input  word_t    wb_fwd_i,
  output logic     redirect_o,
  output word_t    target_o,
  output ex_mem_t  ex_mem_o
);

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_result;
  logic  rs_equal;
  logic  branch_taken;

  function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                    word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  // ========================================
  // operands
  // ========================================
  assign op_a    = fwd_mux(fwd_a_i, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);
  assign op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_val;

  always_comb begin
    case (id_ex_i.ctrl.alu_op)
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_SLL:    alu_result = op_a << op_b[4:0];
      ALU_SRL:    alu_result = op_a >> op_b[4:0];
      ALU_SRA:    alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // ========================================
  // branch and jump resolution
  // ========================================
  assign rs_equal     = (op_a == rs2_val);
  assign branch_taken = id_ex_i.ctrl.branch & (rs_equal ^ id_ex_i.ctrl.branch_ne);
  assign redirect_o   = id_ex_i.valid & (branch_taken | id_ex_i.ctrl.jal);
  assign target_o     = id_ex_i.pc + id_ex_i.imm;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_o <= '0;
    end else if (en_i) begin
      ex_mem_o.pc         <= id_ex_i.pc;
      ex_mem_o.rd         <= id_ex_i.rd;
      // jal writes the link address
      ex_mem_o.result     <= id_ex_i.ctrl.jal ? id_ex_i.pc + 32'd4 : alu_result;
      ex_mem_o.store_data <= rs2_val;
      ex_mem_o.ctrl       <= id_ex_i.ctrl;
      ex_mem_o.valid      <= id_ex_i.valid;
    end
  end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  logic     en_i,
  input  logic     flush_i,
  input  if_id_t   if_id_i,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  input  word_t    rdata1_i,
  input  word_t    rdata2_i,
  output id_ex_t   id_ex_o
);

  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  ctrl_t      ctrl;
  word_t      imm;
  id_ex_t     id_ex_d;

  assign instr     = if_id_i.instr;
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];
  assign rs1_o     = instr[19:15];
  assign rs2_o     = instr[24:20];

  // shared by register and immediate forms
  function automatic alu_op_e alu_from_funct(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    imm         = '0;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_from_funct(funct3, funct7_b5);
      end
      OPC_OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        // only the shift-right form reads funct7, there is no subi
        ctrl.alu_op      = alu_from_funct(funct3, funct7_b5 & (funct3 == 3'b101));
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      OPC_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_PASS_B;
        imm              = {instr[31:12], 12'h000};
      end
      OPC_LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      OPC_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = funct3[0];
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  always_comb begin
    id_ex_d.pc       = if_id_i.pc;
    id_ex_d.rs1      = rs1_o;
    id_ex_d.rs2      = rs2_o;
    id_ex_d.rd       = instr[11:7];
    id_ex_d.rs1_data = rdata1_i;
    id_ex_d.rs2_data = rdata2_i;
    id_ex_d.imm      = imm;
    id_ex_d.ctrl     = ctrl;
    // the flush pattern in if_id marks a bubble
    id_ex_d.valid    = (instr != NOP_INST);
  end

  // ========================================
  // decode to execute register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o <= '0;
    end else if (en_i) begin
      id_ex_o <= flush_i ? id_ex_t'('0) : id_ex_d;
    end
  end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage
  import rv_core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic   clk,
  input  logic   rst_i,
  input  logic   en_i,
  input  logic   flush_i,
  input  logic   redirect_i,
  input  word_t  target_i,
  output word_t  imem_addr_o,
  input  word_t  imem_data_i,
  output if_id_t if_id_o
);

  word_t pc_q;
  word_t pc_next;

  // taken branch or jal from execute wins over sequential fetch
  assign pc_next     = redirect_i ? target_i : pc_q + 32'd4;
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (en_i) begin
      pc_q <= pc_next;
    end
  end

  // ========================================
  // fetch to decode register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst_i) begin
      if_id_o <= '{pc: RESET_PC, instr: NOP_INST};
    end else if (en_i) begin
      if (flush_i) begin
        if_id_o.instr <= NOP_INST;
      end else begin
        if_id_o.pc    <= pc_q;
        if_id_o.instr <= imem_data_i;
      end
    end
  end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  reg_idx_t raddr1_i,
  input  reg_idx_t raddr2_i,
  input  reg_idx_t waddr_i,
  input  logic     we_i,
  input  word_t    wdata_i,
  output word_t    rdata1_o,
  output word_t    rdata2_o
);

  word_t regs [32];

  // x0 stays zero and a same-cycle write shows through
  function automatic word_t read_port(reg_idx_t addr, word_t stored, logic we,
                                      reg_idx_t waddr, word_t wdata);
    if (addr == '0) begin
      return '0;
    end
    if (we && (waddr == addr)) begin
      return wdata;
    end
    return stored;
  endfunction

  assign rdata1_o = read_port(raddr1_i, regs[raddr1_i], we_i, waddr_i, wdata_i);
  assign rdata2_o = read_port(raddr2_i, regs[raddr2_i], we_i, waddr_i, wdata_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // ========================================
  // opcodes of the supported subset
  // ========================================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // addi x0, x0, 0
  localparam word_t NOP_INST = 32'h0000_0013;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_e;

  // ========================================
  // pipeline records
  // ========================================
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;
    logic    jal;
    logic    alu_src_imm;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    ctrl_t    ctrl;
    logic     valid;
  } id_ex_t;

  // result holds the alu value or the link address
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    result;
    word_t    store_data;
    ctrl_t    ctrl;
    logic     valid;
  } ex_mem_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wdata;
    logic     reg_write;
    logic     valid;
  } mem_wb_t;

  typedef struct packed {
    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    logic     reg_write;
    word_t    wdata;
  } retire_t;

endpackage
